// File: cam_array.sv
//========================================
// Binary CAM, 16 entries by 8 bits
// Read and search return after 2 cycles
//========================================
module cam_array (
  input  logic       bist_clk,
  input  logic       rst_n,
  cam_port_if.array  port
);

  logic [cam_bist_pkg::cam_dwidth-1:0]  mem [cam_bist_pkg::cam_entries];
  logic [cam_bist_pkg::cam_dwidth-1:0]  rd_s1;
  logic [cam_bist_pkg::cam_entries-1:0] hit;
  logic [cam_bist_pkg::cam_entries-1:0] hit_s1;

  // Per-entry compare against the search key
  always_comb begin
    for (int i = 0; i < cam_bist_pkg::cam_entries; i++) begin
      hit[i] = (mem[i] == port.key);
    end
  end

  // Storage, write visible from the next edge
  always_ff @(posedge bist_clk) begin
    if (port.we) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  // First stage captures on the strobe
  always_ff @(posedge bist_clk) begin
    if (port.re) begin
      rd_s1 <= mem[port.raddr];
    end
    if (port.srch) begin
      hit_s1 <= hit;
    end
  end

  // Second stage drives the port
  always_ff @(posedge bist_clk) begin
    port.rdata <= rd_s1;
    port.match <= hit_s1;
  end

  // Neither master may read the entry it writes in the same cycle
  a_no_wr_rd_same_addr : assert property (
    @(posedge bist_clk) disable iff (!rst_n)
    !(port.we && port.re && (port.waddr == port.raddr))
  ) else $error("write and read of entry %0d in one cycle", port.waddr);

endmodule

// File: cam_bist.f
cam_bist_pkg.sv
cam_port_if.sv
cam_array.sv
cam_port_arbiter.sv
cam_bist_engine.sv
cam_bist_outhandler.sv
cam_bist_checker.sv
cam_bist_top.sv
cam_bist_tb.sv

// File: cam_bist_checker.sv
//========================================
// CAM BIST result checker
// Sticky fail and first failing address
//========================================
module cam_bist_checker (
  input  logic                                bist_clk,
  input  logic                                rst_n,
  input  logic                                bist_start,
  input  logic                                chk_en,
  input  logic                                cm_mode,
  input  cam_bist_pkg::cam_rd_word_u          rd_word,
  input  cam_bist_pkg::cam_rd_word_u          exp_data,
  input  logic [cam_bist_pkg::cam_awidth-1:0] chk_addr,
  output logic                                bist_fail,
  output logic [cam_bist_pkg::cam_awidth-1:0] fail_addr
);

  logic miscompare;

  // CAM mode expects a clean error word, read mode the written data
  assign miscompare = cm_mode ? (rd_word.err != '0) : (rd_word.data != exp_data.data);

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      bist_fail <= 1'b0;
      fail_addr <= '0;
    end else if (bist_start) begin
      bist_fail <= 1'b0;
      fail_addr <= '0;
    end else if (chk_en && miscompare && !bist_fail) begin
      // Only the first failure is kept
      bist_fail <= 1'b1;
      fail_addr <= chk_addr;
    end
  end

  // A CAM mode check carries no expected word from the engine
  a_cam_exp_zero : assert property (
    @(posedge bist_clk) disable iff (!rst_n)
    (chk_en && cm_mode) |-> (exp_data.err == '0)
  ) else $error("non-zero expected word on a CAM mode check");

endmodule

// File: cam_bist_engine.sv
//========================================
// CAM BIST sequencer
// Write/read pass, then four search passes
//========================================
module cam_bist_engine (
  input  logic                                bist_clk,
  input  logic                                rst_n,
  input  logic                                bist_start,
  cam_port_if.master                          port,
  output logic                                bist_busy,
  output logic                                bist_done,
  output logic                                cm_mode,
  output cam_bist_pkg::match_sel_e            match_sel,
  output logic [cam_bist_pkg::cam_awidth-1:0] bist_addr,
  output logic                                chk_en,
  output cam_bist_pkg::cam_rd_word_u          exp_data
);

  cam_bist_pkg::bist_phase_e                                phase;
  logic [cam_bist_pkg::cam_awidth-1:0]                      idx;
  logic [1:0]                                               sub;
  logic [1:0]                                               drn;
  logic [1:0]                                               sub_last;
  logic                                                     one_shot;
  logic                                                     last_op;
  cam_bist_pkg::cam_rd_word_u                               exp_now;
  logic [cam_bist_pkg::cam_rsp_lat-1:0]                     chk_pipe;
  cam_bist_pkg::cam_rd_word_u [cam_bist_pkg::cam_rsp_lat-1:0] exp_pipe;

  //========================================
  // Phase shape
  //========================================
  // Steps per entry, or a single search for the full passes
  always_comb begin
    sub_last = 2'd0;
    one_shot = 1'b0;
    unique case (phase)
      cam_bist_pkg::ph_wr_rd:           sub_last = 2'd1;
      cam_bist_pkg::ph_single_match:    sub_last = 2'd2;
      cam_bist_pkg::ph_single_mismatch: sub_last = 2'd2;
      cam_bist_pkg::ph_all_match:       one_shot = 1'b1;
      cam_bist_pkg::ph_all_mismatch:    one_shot = 1'b1;
      default:                          sub_last = 2'd0;
    endcase
  end

  assign last_op = (sub == sub_last) && (one_shot || (&idx));

  // Two drain cycles after the last op keep the select aligned with responses
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      phase     <= cam_bist_pkg::ph_idle;
      idx       <= '0;
      sub       <= '0;
      drn       <= '0;
      bist_done <= 1'b0;
    end else begin
      bist_done <= 1'b0;
      if (phase == cam_bist_pkg::ph_idle) begin
        if (bist_start) begin
          phase <= cam_bist_pkg::ph_wr_rd;
        end
      end else if (drn != 2'd0) begin
        if (drn == 2'd2) begin
          drn <= '0;
          if (phase == cam_bist_pkg::ph_single_mismatch) begin
            phase     <= cam_bist_pkg::ph_idle;
            bist_done <= 1'b1;
          end else begin
            phase <= cam_bist_pkg::bist_phase_e'(phase + 3'd1);
          end
        end else begin
          drn <= drn + 2'd1;
        end
      end else if (last_op) begin
        drn <= 2'd1;
        idx <= '0;
        sub <= '0;
      end else if (sub == sub_last) begin
        sub <= '0;
        idx <= idx + 1'b1;
      end else begin
        sub <= sub + 2'd1;
      end
    end
  end

  assign bist_busy = (phase != cam_bist_pkg::ph_idle);
  assign bist_addr = idx;

  //========================================
  // Operation decode
  //========================================
  always_comb begin
    port.we    = 1'b0;
    port.re    = 1'b0;
    port.srch  = 1'b0;
    port.waddr = idx;
    port.raddr = idx;
    port.wdata = cam_bist_pkg::pat_base;
    port.key   = cam_bist_pkg::pat_base;
    if (drn == 2'd0) begin
      unique case (phase)
        cam_bist_pkg::ph_wr_rd: begin
          port.we    = (sub == 2'd0);
          port.re    = (sub == 2'd1);
          port.wdata = cam_bist_pkg::bg_table[idx];
        end
        cam_bist_pkg::ph_fill: port.we = 1'b1;
        cam_bist_pkg::ph_all_match: port.srch = 1'b1;
        cam_bist_pkg::ph_all_mismatch: begin
          port.srch = 1'b1;
          port.key  = cam_bist_pkg::pat_miss;
        end
        // Mark entry i, search, then restore the base pattern
        cam_bist_pkg::ph_single_match, cam_bist_pkg::ph_single_mismatch: begin
          port.we    = (sub != 2'd1);
          port.srch  = (sub == 2'd1);
          port.wdata = (sub == 2'd0) ? cam_bist_pkg::pat_single : cam_bist_pkg::pat_base;
          if (phase == cam_bist_pkg::ph_single_match) begin
            port.key = cam_bist_pkg::pat_single;
          end
        end
        default: port.we = 1'b0;
      endcase
    end
  end

  // Mode and expected pattern are a function of the phase only
  always_comb begin
    cm_mode = (phase != cam_bist_pkg::ph_idle) && (phase != cam_bist_pkg::ph_wr_rd);
    unique case (phase)
      cam_bist_pkg::ph_all_mismatch:    match_sel = cam_bist_pkg::all_mismatch;
      cam_bist_pkg::ph_single_match:    match_sel = cam_bist_pkg::single_match;
      cam_bist_pkg::ph_single_mismatch: match_sel = cam_bist_pkg::single_mismatch;
      default:                          match_sel = cam_bist_pkg::all_match;
    endcase
  end

  //========================================
  // Response alignment
  //========================================
  // Read mode expects the background, CAM mode expects no error
  always_comb begin
    if (phase == cam_bist_pkg::ph_wr_rd) begin
      exp_now.data = cam_bist_pkg::bg_table[idx];
    end else begin
      exp_now.err = '0;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      chk_pipe <= '0;
    end else begin
      chk_pipe <= {chk_pipe[cam_bist_pkg::cam_rsp_lat-2:0], port.re | port.srch};
    end
  end

  always_ff @(posedge bist_clk) begin
    exp_pipe <= {exp_pipe[cam_bist_pkg::cam_rsp_lat-2:0], exp_now};
  end

  assign chk_en   = chk_pipe[cam_bist_pkg::cam_rsp_lat-1];
  assign exp_data = exp_pipe[cam_bist_pkg::cam_rsp_lat-1];

endmodule

// File: cam_bist_outhandler.sv
//========================================
// CAM BIST output handler
// Match compare, fold onto read bus
//========================================
module cam_bist_outhandler (
  input  logic                                 bist_clk,
  input  logic                                 cm_mode,
  input  cam_bist_pkg::match_sel_e             match_sel,
  input  logic [cam_bist_pkg::cam_awidth-1:0]  bist_addr,
  input  logic [cam_bist_pkg::cam_entries-1:0] cm_match,
  input  cam_bist_pkg::cam_rd_word_u           rd_data_in,
  output cam_bist_pkg::cam_rd_word_u           rd_data_out,
  output logic [cam_bist_pkg::cam_entries-1:0] match_ref,
  output logic [cam_bist_pkg::cam_awidth-1:0]  addr_dly
);

  logic [cam_bist_pkg::cam_rsp_lat-1:0][cam_bist_pkg::cam_awidth-1:0] addr_pipe;
  logic [cam_bist_pkg::cam_entries-1:0] addr_hot;
  logic [cam_bist_pkg::cam_entries-1:0] err_vec;
  cam_bist_pkg::cam_rd_word_u           err_word;

  //========================================
  // Address delay and expected match lines
  //========================================
  // Address follows the array latency
  always_ff @(posedge bist_clk) begin
    addr_pipe <= {addr_pipe[cam_bist_pkg::cam_rsp_lat-2:0], bist_addr};
  end

  assign addr_dly = addr_pipe[cam_bist_pkg::cam_rsp_lat-1];
  assign addr_hot = {{(cam_bist_pkg::cam_entries-1){1'b0}}, 1'b1} << addr_dly;

  always_comb begin
    unique case (match_sel)
      cam_bist_pkg::all_match:       match_ref = '1;
      cam_bist_pkg::single_match:    match_ref = addr_hot;
      cam_bist_pkg::single_mismatch: match_ref = ~addr_hot;
      default:                       match_ref = '0;
    endcase
  end

  // A set bit marks an entry that answered wrongly
  assign err_vec = match_ref ^ cm_match;

  //========================================
  // Fold and read bus select
  //========================================
  // Entry i and entry i+8 share error bit i
  always_comb begin
    err_word.err = '0;
    for (int i = 0; i < cam_bist_pkg::cam_entries; i++) begin
      err_word.err[i % cam_bist_pkg::cam_dwidth] |= err_vec[i];
    end
  end

  assign rd_data_out = cm_mode ? err_word : rd_data_in;

endmodule

// File: cam_bist_pkg.sv
//========================================
// CAM BIST shared definitions
// Array geometry, test codes, read word
//========================================
package cam_bist_pkg;

  // Array geometry
  localparam int cam_entries = 16;
  localparam int cam_dwidth  = 8;
  localparam int cam_awidth  = 4;

  // Cycles from issue to response
  localparam int cam_rsp_lat = 2;

  // Search patterns
  localparam logic [cam_dwidth-1:0] pat_base   = 8'h3c;
  localparam logic [cam_dwidth-1:0] pat_single = 8'ha5;
  localparam logic [cam_dwidth-1:0] pat_miss   = 8'hc3;

  // Background for the write and read-back pass, one word per entry
  localparam logic [cam_dwidth-1:0] bg_table [cam_entries] = '{
    8'h00, 8'hff, 8'h55, 8'haa, 8'h0f, 8'hf0, 8'h33, 8'hcc,
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80
  };

  // Expected match pattern select
  typedef enum logic [1:0] {
    all_match       = 2'b00,
    single_match    = 2'b01,
    single_mismatch = 2'b10,
    all_mismatch    = 2'b11
  } match_sel_e;

  // Engine phases, in run order
  typedef enum logic [2:0] {
    ph_idle,
    ph_wr_rd,
    ph_fill,
    ph_all_match,
    ph_all_mismatch,
    ph_single_match,
    ph_single_mismatch
  } bist_phase_e;

  // Read bus word, data in read mode, folded error in CAM mode
  typedef union packed {
    logic [cam_dwidth-1:0] data;
    logic [cam_dwidth-1:0] err;
  } cam_rd_word_u;

endpackage

// File: cam_bist_tb.sv
//========================================
// CAM BIST testbench
// Table of functional and BIST steps
//========================================
module cam_bist_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {
    op_idle,
    op_write,
    op_read,
    op_search,
    op_bist,
    op_busy_write
  } op_e;

  // One row of the stimulus table, rnd replaces data with LFSR bits
  typedef struct {
    op_e        op;
    logic [3:0] addr;
    logic [7:0] data;
    logic       rnd;
  } step_t;

  logic        bist_clk;
  logic        rst_n;
  logic        func_we;
  logic [3:0]  func_waddr;
  logic [7:0]  func_wdata;
  logic        func_re;
  logic [3:0]  func_raddr;
  logic        func_srch;
  logic [7:0]  func_key;
  logic [7:0]  func_rdata;
  logic [15:0] func_match;
  logic        func_ready;
  logic        bist_start;
  logic        bist_busy;
  logic        bist_done;
  logic        bist_fail;
  logic [3:0]  fail_addr;

  // Reference model of the array contents
  logic [7:0]  model [16];
  step_t       steps [$];
  logic [31:0] lfsr_state = 32'h1a6d;
  logic        table_built = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          test_errs = 0;

  cam_bist_top i_dut (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .func_we    (func_we),
    .func_waddr (func_waddr),
    .func_wdata (func_wdata),
    .func_re    (func_re),
    .func_raddr (func_raddr),
    .func_srch  (func_srch),
    .func_key   (func_key),
    .func_rdata (func_rdata),
    .func_match (func_match),
    .func_ready (func_ready),
    .bist_start (bist_start),
    .bist_busy  (bist_busy),
    .bist_done  (bist_done),
    .bist_fail  (bist_fail),
    .fail_addr  (fail_addr)
  );

  initial begin
    bist_clk = 1'b0;
    forever #2 bist_clk = ~bist_clk;
  end

  //========================================
  // Helpers
  //========================================
  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic add_step(input op_e op, input logic [3:0] addr, input logic [7:0] data,
                          input logic rnd);
    step_t s;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.rnd = rnd;
    steps.push_back(s);
  endtask

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s got %0h expected %0h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_idle();
    @(negedge bist_clk);
    compare_value("bist_busy", 16'(bist_busy), 16'h0);
    compare_value("bist_done", 16'(bist_done), 16'h0);
    compare_value("bist_fail", 16'(bist_fail), 16'h0);
    compare_value("func_ready", 16'(func_ready), 16'h1);
  endtask

  task automatic do_write(input logic [3:0] addr, input logic [7:0] data);
    @(posedge bist_clk);
    func_we    <= 1'b1;
    func_waddr <= addr;
    func_wdata <= data;
    @(posedge bist_clk);
    func_we    <= 1'b0;
    model[addr] = data;
  endtask

  // Response is valid two edges after the strobe is sampled
  task automatic do_read(input logic [3:0] addr);
    @(posedge bist_clk);
    func_re    <= 1'b1;
    func_raddr <= addr;
    @(posedge bist_clk);
    func_re    <= 1'b0;
    @(posedge bist_clk);
    @(negedge bist_clk);
    compare_value("func_rdata", 16'(func_rdata), 16'(model[addr]));
  endtask

  task automatic do_search(input logic [7:0] key);
    logic [15:0] exp_match;
    for (int e = 0; e < 16; e++) begin
      exp_match[e] = (model[e] == key);
    end
    @(posedge bist_clk);
    func_srch <= 1'b1;
    func_key  <= key;
    @(posedge bist_clk);
    func_srch <= 1'b0;
    @(posedge bist_clk);
    @(negedge bist_clk);
    compare_value("func_match", func_match, exp_match);
  endtask

  // Full BIST run, optionally with a functional write held while busy
  task automatic run_bist(input logic with_write, input logic [3:0] addr,
                          input logic [7:0] data);
    logic done_seen;
    done_seen = 1'b0;
    @(posedge bist_clk);
    bist_start <= 1'b1;
    @(posedge bist_clk);
    bist_start <= 1'b0;
    @(negedge bist_clk);
    compare_value("bist_busy", 16'(bist_busy), 16'h1);
    compare_value("func_ready", 16'(func_ready), 16'h0);
    if (with_write) begin
      // Dropped on every edge of the run, so no BIST phase sees the entry move
      @(posedge bist_clk);
      func_we    <= 1'b1;
      func_waddr <= addr;
      func_wdata <= data;
    end
    while (!done_seen) begin
      @(negedge bist_clk);
      if (bist_done) begin
        done_seen = 1'b1;
      end else begin
        compare_value("bist_busy", 16'(bist_busy), 16'h1);
      end
    end
    compare_value("bist_fail", 16'(bist_fail), 16'h0);
    compare_value("fail_addr", 16'(fail_addr), 16'h0);
    compare_value("bist_busy", 16'(bist_busy), 16'h0);
    // Last search pass restores the base pattern everywhere
    for (int e = 0; e < 16; e++) begin
      model[e] = 8'h3c;
    end
    if (with_write) begin
      // Strobe is still up on the first free edge and lands there
      @(posedge bist_clk);
      func_we <= 1'b0;
      model[addr] = data;
    end
  endtask

  //========================================
  // Main sequence
  //========================================
  initial begin
    step_t      st;
    logic [7:0] val;
    func_we    = 1'b0;
    func_waddr = '0;
    func_wdata = '0;
    func_re    = 1'b0;
    func_raddr = '0;
    func_srch  = 1'b0;
    func_key   = '0;
    bist_start = 1'b0;
    rst_n      = 1'b0;

    add_step(op_idle, 4'd0, 8'h00, 1'b0);
    for (int a = 0; a < 16; a++) begin
      add_step(op_write, 4'(a), 8'h00, 1'b1);
    end
    for (int a = 0; a < 16; a++) begin
      add_step(op_read, 4'(a), 8'h00, 1'b0);
    end
    // Several, one and random-key matches
    add_step(op_write, 4'd3, 8'h5a, 1'b0);
    add_step(op_write, 4'd9, 8'h5a, 1'b0);
    add_step(op_write, 4'd14, 8'h5a, 1'b0);
    add_step(op_write, 4'd12, 8'h77, 1'b0);
    add_step(op_search, 4'd0, 8'h5a, 1'b0);
    add_step(op_search, 4'd0, 8'h77, 1'b0);
    add_step(op_search, 4'd0, 8'h00, 1'b1);
    add_step(op_bist, 4'd0, 8'h00, 1'b0);
    add_step(op_idle, 4'd0, 8'h00, 1'b0);
    for (int a = 0; a < 16; a++) begin
      add_step(op_read, 4'(a), 8'h00, 1'b0);
    end
    add_step(op_write, 4'd5, 8'h11, 1'b0);
    // Held write of the final BIST value, so only a leak can disturb the run
    add_step(op_busy_write, 4'd5, 8'h3c, 1'b0);
    add_step(op_read, 4'd5, 8'h00, 1'b0);
    add_step(op_search, 4'd0, 8'h3c, 1'b0);
    add_step(op_search, 4'd0, 8'h99, 1'b0);
    table_built = 1'b1;

    repeat (3) @(posedge bist_clk);
    rst_n <= 1'b1;

    foreach (steps[i]) begin
      st = steps[i];
      val = st.data;
      test_errs = 0;
      if (st.rnd) begin
        draw_byte(val);
      end
      case (st.op)
        op_idle:       check_idle();
        op_write:      do_write(st.addr, val);
        op_read:       do_read(st.addr);
        op_search:     do_search(val);
        op_bist:       run_bist(1'b0, st.addr, val);
        op_busy_write: run_bist(1'b1, st.addr, val);
        default:       check_idle();
      endcase
      $display("test %0d %s addr %0h data %0h: %s", i, st.op.name(), st.addr, val,
               (test_errs == 0) ? "ok" : "FAILED");
    end

    $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of 40 cycles per step plus the BIST runs
  initial begin
    wait (table_built);
    repeat (steps.size() * 40 + 2000) @(posedge bist_clk);
    $display("Timeout: the run did not finish within the cycle budget");
    $display("Test failures found");
    $finish;
  end

endmodule

// File: cam_bist_top.sv
//========================================
// CAM with BIST, top level
//========================================
module cam_bist_top (
  input  logic                                 bist_clk,
  input  logic                                 rst_n,
  input  logic                                 func_we,
  input  logic [cam_bist_pkg::cam_awidth-1:0]  func_waddr,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  func_wdata,
  input  logic                                 func_re,
  input  logic [cam_bist_pkg::cam_awidth-1:0]  func_raddr,
  input  logic                                 func_srch,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  func_key,
  output logic [cam_bist_pkg::cam_dwidth-1:0]  func_rdata,
  output logic [cam_bist_pkg::cam_entries-1:0] func_match,
  output logic                                 func_ready,
  input  logic                                 bist_start,
  output logic                                 bist_busy,
  output logic                                 bist_done,
  output logic                                 bist_fail,
  output logic [cam_bist_pkg::cam_awidth-1:0]  fail_addr
);

  cam_bist_pkg::match_sel_e                   match_sel;
  cam_bist_pkg::cam_rd_word_u                 exp_data;
  cam_bist_pkg::cam_rd_word_u                 rd_word;
  logic                                       cm_mode;
  logic                                       chk_en;
  logic [cam_bist_pkg::cam_awidth-1:0]        bist_addr;
  logic [cam_bist_pkg::cam_awidth-1:0]        chk_addr;

  cam_port_if func_if ();
  cam_port_if bist_if ();
  cam_port_if arr_if ();

  // Functional user side
  assign func_if.we    = func_we;
  assign func_if.waddr = func_waddr;
  assign func_if.wdata = func_wdata;
  assign func_if.re    = func_re;
  assign func_if.raddr = func_raddr;
  assign func_if.srch  = func_srch;
  assign func_if.key   = func_key;
  assign func_rdata    = func_if.rdata;
  assign func_match    = func_if.match;
  // Strobes given while busy are dropped
  assign func_ready    = ~bist_busy;

  cam_array i_array (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .port     (arr_if.array)
  );

  cam_port_arbiter i_arbiter (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .bist_sel (bist_busy),
    .func_m   (func_if.array),
    .bist_m   (bist_if.array),
    .arr      (arr_if.master)
  );

  cam_bist_engine i_engine (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .bist_start (bist_start),
    .port       (bist_if.master),
    .bist_busy  (bist_busy),
    .bist_done  (bist_done),
    .cm_mode    (cm_mode),
    .match_sel  (match_sel),
    .bist_addr  (bist_addr),
    .chk_en     (chk_en),
    .exp_data   (exp_data)
  );

  cam_bist_outhandler i_outhandler (
    .bist_clk    (bist_clk),
    .cm_mode     (cm_mode),
    .match_sel   (match_sel),
    .bist_addr   (bist_addr),
    .cm_match    (bist_if.match),
    .rd_data_in  (bist_if.rdata),
    .rd_data_out (rd_word),
    .match_ref   (),
    .addr_dly    (chk_addr)
  );

  cam_bist_checker i_checker (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .bist_start (bist_start),
    .chk_en     (chk_en),
    .cm_mode    (cm_mode),
    .rd_word    (rd_word),
    .exp_data   (exp_data),
    .chk_addr   (chk_addr),
    .bist_fail  (bist_fail),
    .fail_addr  (fail_addr)
  );

endmodule

// File: cam_port_arbiter.sv
//========================================
// Array port arbiter
// BIST owns the array while a test runs
//========================================
module cam_port_arbiter (
  input  logic        bist_clk,
  input  logic        rst_n,
  input  logic        bist_sel,
  cam_port_if.array   func_m,
  cam_port_if.array   bist_m,
  cam_port_if.master  arr
);

  // Strobes of the idle master are gated off
  assign arr.we    = bist_sel ? bist_m.we : func_m.we;
  assign arr.re    = bist_sel ? bist_m.re : func_m.re;
  assign arr.srch  = bist_sel ? bist_m.srch : func_m.srch;

  // Address and data follow the owner
  assign arr.waddr = bist_sel ? bist_m.waddr : func_m.waddr;
  assign arr.wdata = bist_sel ? bist_m.wdata : func_m.wdata;
  assign arr.raddr = bist_sel ? bist_m.raddr : func_m.raddr;
  assign arr.key   = bist_sel ? bist_m.key : func_m.key;

  // Responses go back to both masters
  assign func_m.rdata = arr.rdata;
  assign func_m.match = arr.match;
  assign bist_m.rdata = arr.rdata;
  assign bist_m.match = arr.match;

  // The engine issues nothing while it does not own the port
  a_bist_quiet_idle : assert property (
    @(posedge bist_clk) disable iff (!rst_n)
    !bist_sel |-> !(bist_m.we || bist_m.re || bist_m.srch)
  ) else $error("BIST strobe issued without owning the array port");

endmodule

// File: cam_port_if.sv
//========================================
// CAM access port
// Write, read and search toward the array
//========================================
interface cam_port_if;

  // Write port
  logic                                 we;
  logic [cam_bist_pkg::cam_awidth-1:0]  waddr;
  logic [cam_bist_pkg::cam_dwidth-1:0]  wdata;

  // Read port
  logic                                 re;
  logic [cam_bist_pkg::cam_awidth-1:0]  raddr;
  logic [cam_bist_pkg::cam_dwidth-1:0]  rdata;

  // Search port, one match line per entry
  logic                                 srch;
  logic [cam_bist_pkg::cam_dwidth-1:0]  key;
  logic [cam_bist_pkg::cam_entries-1:0] match;

  modport master (
    output we, waddr, wdata, re, raddr, srch, key,
    input  rdata, match
  );

  modport array (
    input  we, waddr, wdata, re, raddr, srch, key,
    output rdata, match
  );

endinterface

// File: run_sim.sh
#!/bin/sh
# Build and run the CAM BIST testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module cam_bist_tb \
  -f cam_bist.f \
  -o cam_bist_sim

./obj_dir/cam_bist_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^All tests passed!$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
